// ==== flist.f ====
src/dsp_pkg.sv
src/cmd_pkg.sv
src/cmd_stream_if.sv
src/cmd_player.sv
src/cmd_fifo.sv
src/cmd_dispatch.sv
src/qubic_dsp_top.sv
verif/tb_qubic_dsp.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the qubic_dsp testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module tb_qubic_dsp \
	--Mdir obj_dir -o tb_qubic_dsp \
	-f flist.f

# the simulator exits nonzero on a failed check, the search below decides
sim_out=$(./obj_dir/tb_qubic_dsp 2>&1) || true
echo "$sim_out"

if grep -q "^TEST OK$" <<< "$sim_out"; then
	exit 0
else
	exit 1
fi

// ==== src/cmd_dispatch.sv ====
`default_nettype none

module cmd_dispatch (
	input  wire                              dsp,
	input  wire                              rst_n,
	input  dsp_pkg::sample_t                 dac_dc [dsp_pkg::n_dac],
	cmd_stream_if.sink                       in,
	output dsp_pkg::dac_word_t               dac_out [dsp_pkg::n_dac],
	output logic [cmd_pkg::n_mark-1:0]       mark,
	output logic                             waiting
);

	localparam int sw = dsp_pkg::sample_w;

	logic                       accept;
	logic [dsp_pkg::n_dac-1:0]  dac_sel;
	logic [cmd_pkg::n_mark-1:0] mark_sel;
	logic                       wait_sel;
	logic [cmd_pkg::wait_w-1:0] wait_cnt;

	// blocked only by a running wait
	assign waiting  = wait_cnt != '0;
	assign in.ready = !waiting;
	assign accept   = in.valid && in.ready;

	// address decode, unknown cmda just gets consumed
	always_comb begin
		for (int c = 0; c < dsp_pkg::n_dac; c++) begin
			dac_sel[c] = accept && (in.item.cmda == cmd_pkg::cmda_dac_base + 8'(c));
		end
		for (int m = 0; m < cmd_pkg::n_mark; m++) begin
			mark_sel[m] = accept && (in.item.cmda == cmd_pkg::cmda_mark_base + 8'(m));
		end
		wait_sel = accept && (in.item.cmda == cmd_pkg::cmda_wait);
	end

	// DAC levels, slice plus DC offset, wraps at 16 bits
	always_ff @(posedge dsp or negedge rst_n) begin
		if (!rst_n) begin
			for (int c = 0; c < dsp_pkg::n_dac; c++) begin
				dac_out[c] <= '0;
			end
		end else begin
			for (int c = 0; c < dsp_pkg::n_dac; c++) begin
				if (dac_sel[c]) begin
					for (int k = 0; k < dsp_pkg::n_slice; k++) begin
						dac_out[c][k] <= in.item.command[k*sw +: sw] + dac_dc[c];
					end
				end
			end
		end
	end

	// marker pins follow command bit 0
	always_ff @(posedge dsp or negedge rst_n) begin
		if (!rst_n) begin
			mark <= '0;
		end else begin
			for (int m = 0; m < cmd_pkg::n_mark; m++) begin
				if (mark_sel[m]) begin
					mark[m] <= in.item.command[0];
				end
			end
		end
	end

	// wait down-counter
	always_ff @(posedge dsp or negedge rst_n) begin
		if (!rst_n) begin
			wait_cnt <= '0;
		end else if (wait_sel) begin
			wait_cnt <= in.item.command[cmd_pkg::wait_w-1:0];
		end else if (waiting) begin
			wait_cnt <= wait_cnt - 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== src/cmd_fifo.sv ====
`default_nettype none

module cmd_fifo #(
	parameter int  fifo_aw = 3,
	parameter type item_t  = cmd_pkg::cmd_t
) (
	input  wire          dsp,
	input  wire          rst_n,
	cmd_stream_if.sink   in,
	cmd_stream_if.source out,
	output logic         empty
);

	localparam int depth = 2**fifo_aw;

	item_t mem [depth];

	// extra msb tells full from empty
	logic [fifo_aw:0] wr_ptr;
	logic [fifo_aw:0] rd_ptr;

	logic full;
	logic push;
	logic pop;

	assign empty = wr_ptr == rd_ptr;
	assign full  = (wr_ptr ^ rd_ptr) == {1'b1, {fifo_aw{1'b0}}};

	// full still takes a push when the head leaves
	assign in.ready = !full || out.ready;

	assign push = in.valid && in.ready;
	assign pop  = out.valid && out.ready;

	always_ff @(posedge dsp) begin
		if (push) begin
			mem[wr_ptr[fifo_aw-1:0]] <= in.item;
		end
	end

	always_ff @(posedge dsp or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// head straight out of the storage flops
	assign out.valid = !empty;
	assign out.item  = mem[rd_ptr[fifo_aw-1:0]];

endmodule

`default_nettype wire

// ==== src/cmd_pkg.sv ====
`default_nettype none

package cmd_pkg;

	localparam int cmda_w = 8;
	localparam int word_w = 64;
	localparam int wait_w = 16;  // wait count, command bits 15:0

	// sequencer entry, cmda on top like the program memory image
	typedef struct packed {
		logic [cmda_w-1:0] cmda;
		logic [word_w-1:0] command;
	} cmd_t;

	// command address map
	localparam logic [cmda_w-1:0] cmda_dac_base  = 8'd0;   // 0..7
	localparam logic [cmda_w-1:0] cmda_mark_base = 8'd16;  // 16..19
	localparam logic [cmda_w-1:0] cmda_wait      = 8'd32;

	localparam int n_mark = 4;

	// default program depth is 2**prog_aw_def entries
	localparam int prog_aw_def = 6;

endpackage

`default_nettype wire

// ==== src/cmd_player.sv ====
`default_nettype none

module cmd_player #(
	parameter int prog_aw = 6
) (
	input  wire                 dsp,
	input  wire                 rst_n,
	input  wire                 prog_wr_en,
	input  wire [prog_aw-1:0]   prog_wr_addr,
	input  cmd_pkg::cmd_t       prog_wr_data,
	input  wire [prog_aw:0]     prog_len,
	input  wire                 trig,
	cmd_stream_if.source        out,
	output logic                busy
);

	cmd_pkg::cmd_t mem [2**prog_aw];

	logic [prog_aw:0] rd_ptr;  // next entry to fetch
	logic [prog_aw:0] len_q;
	logic             valid_q;
	cmd_pkg::cmd_t    item_q;

	logic free;
	logic more;
	logic load;
	logic finish;

	// host port
	always_ff @(posedge dsp) begin
		if (prog_wr_en) begin
			mem[prog_wr_addr] <= prog_wr_data;
		end
	end

	// output slot empty or draining this edge
	assign free   = !valid_q || out.ready;
	assign more   = rd_ptr != len_q;
	assign load   = busy && free && more;
	assign finish = busy && free && !more;

	always_ff @(posedge dsp or negedge rst_n) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			valid_q <= 1'b0;
			rd_ptr  <= '0;
			len_q   <= '0;
		end else if (!busy) begin
			if (trig) begin  // trig only seen while idle
				busy   <= 1'b1;
				rd_ptr <= '0;
				len_q  <= prog_len;
			end
		end else if (load) begin
			valid_q <= 1'b1;
			rd_ptr  <= rd_ptr + 1'b1;
		end else if (finish) begin
			// last entry handed over, or empty program
			valid_q <= 1'b0;
			busy    <= 1'b0;
		end
	end

	// registered read stage, held while stalled
	always_ff @(posedge dsp) begin
		if (load) begin
			item_q <= mem[rd_ptr[prog_aw-1:0]];
		end
	end

	assign out.valid = valid_q;
	assign out.item  = item_q;

endmodule

`default_nettype wire

// ==== src/cmd_stream_if.sv ====
`default_nettype none

interface cmd_stream_if #(
	parameter type item_t = cmd_pkg::cmd_t
) ();

	logic  valid;
	logic  ready;
	item_t item;

	// transfer on dsp edge with valid & ready
	modport source (
		output valid,
		output item,
		input  ready
	);

	modport sink (
		input  valid,
		input  item,
		output ready
	);

endinterface

`default_nettype wire

// ==== src/dsp_pkg.sv ====
`default_nettype none

package dsp_pkg;

	// DAC datapath geometry
	localparam int sample_w = 16;
	localparam int n_slice  = 4;  // time slices per dsp clock
	localparam int n_dac    = 8;

	// one signed DAC sample
	typedef logic signed [sample_w-1:0] sample_t;

	// one channel for one clock, slice k at bits 16k+15:16k
	typedef sample_t [n_slice-1:0] dac_word_t;

endpackage

`default_nettype wire

// ==== src/qubic_dsp_top.sv ====
`default_nettype none

module qubic_dsp_top #(
	parameter int prog_aw = cmd_pkg::prog_aw_def,
	parameter int fifo_aw = 3
) (
	input  wire                         dsp,
	input  wire                         rst_n,

	// host program port
	input  wire                         prog_wr_en,
	input  wire [prog_aw-1:0]           prog_wr_addr,
	input  cmd_pkg::cmd_t               prog_wr_data,
	input  wire [prog_aw:0]             prog_len,
	input  wire                         trig,

	input  dsp_pkg::sample_t            dac_dc [dsp_pkg::n_dac],

	output dsp_pkg::dac_word_t          dac_out [dsp_pkg::n_dac],
	output logic [cmd_pkg::n_mark-1:0]  mark,
	output logic                        idle
);

	logic play_busy;
	logic fifo_empty;
	logic waiting;

	cmd_stream_if #(.item_t(cmd_pkg::cmd_t)) play_if ();  // player to fifo
	cmd_stream_if #(.item_t(cmd_pkg::cmd_t)) disp_if ();  // fifo to dispatcher

	cmd_player #(
		.prog_aw      (prog_aw)
	) play (
		.dsp          (dsp),
		.rst_n        (rst_n),
		.prog_wr_en   (prog_wr_en),
		.prog_wr_addr (prog_wr_addr),
		.prog_wr_data (prog_wr_data),
		.prog_len     (prog_len),
		.trig         (trig),
		.out          (play_if.source),
		.busy         (play_busy)
	);

	cmd_fifo #(
		.fifo_aw (fifo_aw),
		.item_t  (cmd_pkg::cmd_t)
	) fifo (
		.dsp     (dsp),
		.rst_n   (rst_n),
		.in      (play_if.sink),
		.out     (disp_if.source),
		.empty   (fifo_empty)
	);

	cmd_dispatch disp (
		.dsp     (dsp),
		.rst_n   (rst_n),
		.dac_dc  (dac_dc),
		.in      (disp_if.sink),
		.dac_out (dac_out),
		.mark    (mark),
		.waiting (waiting)
	);

	// run done once nothing is queued or pending
	assign idle = !play_busy && fifo_empty && !waiting;

endmodule

`default_nettype wire

// ==== verif/tb_qubic_dsp.sv ====
`default_nettype none

module tb_qubic_dsp;

	localparam int prog_aw    = 6;
	localparam int fifo_aw    = 2;  // shallow, so a wait backs up into the player
	localparam int n_rows     = 6;
	localparam int max_cmd    = 8;
	localparam int idle_limit = 1000;

	logic                          dsp;
	logic                          rst_n;
	logic                          prog_wr_en;
	logic [prog_aw-1:0]            prog_wr_addr;
	cmd_pkg::cmd_t                 prog_wr_data;
	logic [prog_aw:0]              prog_len;
	logic                          trig;
	dsp_pkg::sample_t              dac_dc [dsp_pkg::n_dac];
	dsp_pkg::dac_word_t            dac_out [dsp_pkg::n_dac];
	logic [cmd_pkg::n_mark-1:0]    mark;
	logic                          idle;

	// stimulus table, one program per row
	cmd_pkg::cmd_t                 prog_tab [n_rows][max_cmd];
	int                            len_tab [n_rows];
	bit                            new_dc_tab [n_rows];
	logic [cmd_pkg::n_mark-1:0]    mark_tab [n_rows];  // expected pins after the row

	// reference state
	dsp_pkg::dac_word_t            exp_dac [dsp_pkg::n_dac];
	logic [cmd_pkg::n_mark-1:0]    exp_mark;

	integer seed;

	qubic_dsp_top #(
		.prog_aw      (prog_aw),
		.fifo_aw      (fifo_aw)
	) i_dut (
		.dsp          (dsp),
		.rst_n        (rst_n),
		.prog_wr_en   (prog_wr_en),
		.prog_wr_addr (prog_wr_addr),
		.prog_wr_data (prog_wr_data),
		.prog_len     (prog_len),
		.trig         (trig),
		.dac_dc       (dac_dc),
		.dac_out      (dac_out),
		.mark         (mark),
		.idle         (idle)
	);

	initial begin
		dsp = 1'b0;
		forever #10 dsp = ~dsp;
	end

	task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("error at %0t: %s got %h expected %h", $time, what, got, exp);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic put_cmd(input int r, input int i, input logic [7:0] a, input logic [63:0] w);
		prog_tab[r][i].cmda    = a;
		prog_tab[r][i].command = w;
	endtask

	task automatic set_row(input int r, input int len, input bit new_dc,
			input logic [cmd_pkg::n_mark-1:0] m);
		len_tab[r]    = len;
		new_dc_tab[r] = new_dc;
		mark_tab[r]   = m;
	endtask

	task automatic fill_table();
		for (int r = 0; r < n_rows; r++) begin
			for (int i = 0; i < max_cmd; i++) begin
				put_cmd(r, i, 8'd0, 64'd0);
			end
		end
		// row 0, every DAC channel once, ch 7 wraps for any nonzero offset
		for (int c = 0; c < 7; c++) begin
			put_cmd(0, c, 8'(c), 64'h0123_4567_89ab_cdef + 64'(c) * 64'h1111_2222_3333_4444);
		end
		put_cmd(0, 7, 8'd7, 64'hffff_ffff_ffff_ffff);
		set_row(0, 8, 1'b1, 4'b0000);
		// row 1, marker set and clear, only bit 0 counts
		put_cmd(1, 0, 8'd16, 64'h0000_0000_0000_0001);
		put_cmd(1, 1, 8'd18, 64'hffff_0000_0000_0003);
		put_cmd(1, 2, 8'd17, 64'h0000_0000_0000_0001);
		put_cmd(1, 3, 8'd19, 64'h8000_0000_0000_0001);
		put_cmd(1, 4, 8'd16, 64'hffff_ffff_ffff_fffe);
		put_cmd(1, 5, 8'd17, 64'h0000_0000_0000_0000);
		set_row(1, 6, 1'b0, 4'b1100);
		// row 2, repeated channels, last one wins
		put_cmd(2, 0, 8'd3, 64'h1111_1111_1111_1111);
		put_cmd(2, 1, 8'd5, 64'h2222_2222_2222_2222);
		put_cmd(2, 2, 8'd3, 64'h3333_3333_3333_3333);
		put_cmd(2, 3, 8'd17, 64'h0000_0000_0000_0001);
		put_cmd(2, 4, 8'd5, 64'hdead_beef_0bad_f00d);
		put_cmd(2, 5, 8'd3, 64'h4444_4444_4444_4444);
		put_cmd(2, 6, 8'd3, 64'h7fff_8000_0001_fffe);
		set_row(2, 7, 1'b1, 4'b1110);
		// row 3, long wait then a queue deeper than the FIFO
		put_cmd(3, 0, 8'd32, 64'h0000_0000_0000_003c);
		put_cmd(3, 1, 8'd0, 64'ha5a5_5a5a_a5a5_5a5a);
		put_cmd(3, 2, 8'd1, 64'h0f0f_f0f0_0f0f_f0f0);
		put_cmd(3, 3, 8'd16, 64'h0000_0000_0000_0000);
		put_cmd(3, 4, 8'd2, 64'h1234_5678_9abc_def0);
		put_cmd(3, 5, 8'd19, 64'h0000_0000_0000_0000);
		put_cmd(3, 6, 8'd0, 64'hcafe_babe_f00d_face);
		put_cmd(3, 7, 8'd6, 64'h0001_0002_0003_0004);
		set_row(3, 8, 1'b0, 4'b0110);
		// row 4, addresses outside the map
		put_cmd(4, 0, 8'd8, 64'hffff_ffff_ffff_ffff);
		put_cmd(4, 1, 8'd15, 64'h1111_2222_3333_4444);
		put_cmd(4, 2, 8'd21, 64'h0000_0000_0000_0001);
		put_cmd(4, 3, 8'd31, 64'h0000_0000_0000_0001);
		put_cmd(4, 4, 8'd33, 64'h0000_0000_0000_0fff);
		put_cmd(4, 5, 8'd255, 64'h5555_aaaa_5555_aaaa);
		set_row(4, 6, 1'b1, 4'b0110);
		// row 5, stale program that must not play
		for (int i = 0; i < max_cmd; i++) begin
			put_cmd(5, i, (i % 2 == 0) ? 8'(i) : 8'(16 + i / 2), 64'hffff_ffff_ffff_ffff);
		end
		set_row(5, 0, 1'b1, 4'b0110);
	endtask

	task automatic draw_dc();
		logic [31:0] v;
		for (int c = 0; c < dsp_pkg::n_dac; c++) begin
			v = $random(seed);
			if (v[15:0] == 16'd0) begin
				v[0] = 1'b1;  // keep the wrap case live
			end
			dac_dc[c] = v[15:0];
		end
	endtask

	// decode rules applied in program order
	task automatic apply_model(input cmd_pkg::cmd_t cmd);
		int c;
		if (cmd.cmda < 8'd8) begin
			c = int'(cmd.cmda);
			for (int k = 0; k < 4; k++) begin
				exp_dac[c][k] = cmd.command[16*k +: 16] + dac_dc[c];
			end
		end else if (cmd.cmda >= 8'd16 && cmd.cmda <= 8'd19) begin
			exp_mark[cmd.cmda - 8'd16] = cmd.command[0];
		end
	endtask

	task automatic load_and_trigger(input int r);
		@(negedge dsp);
		if (new_dc_tab[r]) begin
			draw_dc();
		end
		for (int i = 0; i < max_cmd; i++) begin
			prog_wr_en   = 1'b1;
			prog_wr_addr = prog_aw'(i);
			prog_wr_data = prog_tab[r][i];
			@(negedge dsp);
		end
		prog_wr_en = 1'b0;
		prog_len   = (prog_aw+1)'(len_tab[r]);
		trig       = 1'b1;
		@(negedge dsp);
		trig = 1'b0;
		// player busy from the edge that saw trig
		check($sformatf("row %0d idle after trig", r), 64'(idle), 64'd0);
	endtask

	task automatic wait_idle(input int r);
		int cycles;
		cycles = 0;
		while (!idle) begin
			@(negedge dsp);
			cycles++;
			if (cycles > idle_limit) begin
				$display("timeout: idle did not return within %0d cycles in row %0d",
					idle_limit, r);
				$display("TEST FAILED");
				$fatal(1, "timeout");
			end
		end
	endtask

	task automatic compare_outputs(input int r);
		for (int c = 0; c < dsp_pkg::n_dac; c++) begin
			check($sformatf("row %0d dac_out[%0d]", r, c), 64'(dac_out[c]), 64'(exp_dac[c]));
		end
		check($sformatf("row %0d mark vs model", r), 64'(mark), 64'(exp_mark));
		check($sformatf("row %0d mark vs table", r), 64'(mark), 64'(mark_tab[r]));
	endtask

	initial begin
		seed         = 32'h4f11_827e;
		rst_n        = 1'b0;
		prog_wr_en   = 1'b0;
		prog_wr_addr = '0;
		prog_wr_data = '0;
		prog_len     = '0;
		trig         = 1'b0;
		for (int c = 0; c < dsp_pkg::n_dac; c++) begin
			dac_dc[c]  = '0;
			exp_dac[c] = '0;
		end
		exp_mark = '0;
		fill_table();

		repeat (2) @(negedge dsp);
		rst_n = 1'b1;
		@(negedge dsp);

		// state straight out of reset
		for (int c = 0; c < dsp_pkg::n_dac; c++) begin
			check($sformatf("reset dac_out[%0d]", c), 64'(dac_out[c]), 64'd0);
		end
		check("reset mark", 64'(mark), 64'd0);
		check("reset idle", 64'(idle), 64'd1);

		for (int r = 0; r < n_rows; r++) begin
			load_and_trigger(r);
			wait_idle(r);
			for (int i = 0; i < len_tab[r]; i++) begin
				apply_model(prog_tab[r][i]);
			end
			compare_outputs(r);
		end

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire
